// ==== src.f ====
+incdir+src
src/buf_pkg.sv
src/queue_pkg.sv
src/slot_allocator.sv
src/port_queue.sv
src/slot_release.sv
src/pkt_buf_mgr.sv
bench/tb_pkt_buf_mgr.sv

// ==== Makefile ====
TB_TOP = tb_pkt_buf_mgr

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module pkt_buf_mgr

sim:
	verilator --binary --timing -f src.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out=$$(./obj_dir/$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

// ==== bench/tb_pkt_buf_mgr.sv ====
// packet buffer manager testbench
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cfg.svh"

module tb_pkt_buf_mgr;
    import buf_pkg::*;
    import queue_pkg::*;

    localparam int QUIET_MIN = `NUM_SLOTS + 2;  // edges with no read start before a must-accept

    logic                        clk;
    logic                        rst;
    logic                        wea;
    len_t                        w_size;
    prio_t                       prio;
    port_t                       dest_port;
    addr_t                       write_address;
    logic                        writing;
    logic                        wr_drop;
    logic [`NUM_PORTS-1:0]       rd_req;
    prio_t [`NUM_PORTS-1:0]      rd_prio;
    addr_t [`NUM_PORTS-1:0]      rd_addr;
    logic [`NUM_PORTS-1:0]       reading;

    logic [15:0] lfsr;

    // model fifos of base and length, one per queue
    int m_base [`NUM_PORTS][`NUM_PRIO][`Q_DEPTH];
    int m_len  [`NUM_PORTS][`NUM_PRIO][`Q_DEPTH];
    int m_head [`NUM_PORTS][`NUM_PRIO];
    int m_cnt  [`NUM_PORTS][`NUM_PRIO];
    bit out_map [`NUM_SLOTS];               // slots still outstanding
    int n_out;
    int n_accept;
    int quiet;                              // edges since the last read start

    // strobes driven at the last falling edge
    bit wr_try;
    int wr_port;
    int wr_prio;
    int wr_len;
    bit rd_try [`NUM_PORTS];
    int rd_q_prio [`NUM_PORTS];

    // enqueue lands in the port fifo one edge after the accept
    bit enq_pend;
    int pend_port;
    int pend_prio;
    int pend_base;
    int pend_len;

    int wr_beats;
    int wr_addr_exp;
    int rd_beats [`NUM_PORTS];
    int rd_addr_exp [`NUM_PORTS];

    pkt_buf_mgr dut0 (
        .clk           (clk),
        .rst           (rst),
        .wea           (wea),
        .w_size        (w_size),
        .prio          (prio),
        .dest_port     (dest_port),
        .write_address (write_address),
        .writing       (writing),
        .wr_drop       (wr_drop),
        .rd_req        (rd_req),
        .rd_prio       (rd_prio),
        .rd_addr       (rd_addr),
        .reading       (reading)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);   // newest bit
        end
        return v;
    endfunction

    task automatic check_eq(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout while %s", what);
        $display("sim failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic push_model(input int p, input int q, input int base, input int len);
        int idx;
        idx = (m_head[p][q] + m_cnt[p][q]) % `Q_DEPTH;
        m_base[p][q][idx] = base;
        m_len[p][q][idx]  = len;
        m_cnt[p][q]++;
    endtask

    // record what the DUT must do at the next rising edge
    task automatic predict();
        wr_try  = wea && !writing;
        wr_port = int'(dest_port);
        wr_prio = int'(prio);
        wr_len  = int'(w_size);
        for (int p = 0; p < `NUM_PORTS; p++) begin
            rd_q_prio[p] = int'(rd_prio[p]);
            rd_try[p]    = rd_req[p] && !reading[p] && (m_cnt[p][rd_q_prio[p]] > 0);
        end
    endtask

    task automatic observe();
        int base;
        int q;
        bit must_drop;
        bit must_take;
        bit started;
        started = 1'b0;
        if (enq_pend) begin
            push_model(pend_port, pend_prio, pend_base, pend_len);
            enq_pend = 1'b0;
        end
        if (wr_try) begin
            must_drop = (m_cnt[wr_port][wr_prio] == `Q_DEPTH) || (n_out == `NUM_SLOTS);
            must_take = !must_drop && (quiet >= QUIET_MIN);
            if (must_drop) check_eq(int'(writing), 0, "write taken with no room");
            if (must_take) check_eq(int'(writing), 1, "write dropped with room");
            check_eq(int'(wr_drop), int'(!writing), "wr_drop after write strobe");
            if (writing) begin
                base = int'(write_address);
                check_eq(base % `SLOT_WORDS, 0, "write base alignment");
                check_eq(int'(out_map[base / `SLOT_WORDS]), 0, "write base still outstanding");
                out_map[base / `SLOT_WORDS] = 1'b1;
                n_out++;
                n_accept++;
                enq_pend    = 1'b1;
                pend_port   = wr_port;
                pend_prio   = wr_prio;
                pend_base   = base;
                pend_len    = wr_len;
                wr_beats    = wr_len;
                wr_addr_exp = base;
            end
        end else begin
            check_eq(int'(wr_drop), 0, "wr_drop without write strobe");
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (rd_try[p]) begin
                q              = rd_q_prio[p];
                base           = m_base[p][q][m_head[p][q]];
                rd_beats[p]    = m_len[p][q][m_head[p][q]];
                rd_addr_exp[p] = base;
                m_head[p][q]   = (m_head[p][q] + 1) % `Q_DEPTH;
                m_cnt[p][q]--;
                out_map[base / `SLOT_WORDS] = 1'b0;
                n_out--;
                started = 1'b1;
            end
        end
        check_eq(int'(writing), int'(wr_beats > 0), "writing level");
        if (wr_beats > 0) begin
            check_eq(int'(write_address), wr_addr_exp, "write address");
            wr_addr_exp++;
            wr_beats--;
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            check_eq(int'(reading[p]), int'(rd_beats[p] > 0),
                     $sformatf("reading level port %0d", p));
            if (rd_beats[p] > 0) begin
                check_eq(int'(rd_addr[p]), rd_addr_exp[p], $sformatf("read address port %0d", p));
                rd_addr_exp[p]++;
                rd_beats[p]--;
            end
        end
        if (started) quiet = 0;
        else if (quiet < 1000) quiet++;
    endtask

    task automatic advance();
        predict();
        @(negedge clk);
        observe();
    endtask

    // fill mode crowds few queues with short packets and rare reads
    task automatic run_traffic(input int cycles, input bit fill);
        bit all_rd;
        for (int i = 0; i < cycles; i++) begin
            wea = 1'(rand_bits(1));
            if (fill) begin
                dest_port = port_t'(rand_bits(1));
                prio      = prio_t'(rand_bits(1));
                w_size    = len_t'(1 + rand_bits(2));
            end else begin
                dest_port = port_t'(rand_bits(2));
                prio      = prio_t'(rand_bits(2));
                w_size    = len_t'(1 + rand_bits(5));
            end
            all_rd = fill ? 1'b0 : (rand_bits(3) == 0);  // all ports at once
            for (int p = 0; p < `NUM_PORTS; p++) begin
                rd_prio[p] = prio_t'(rand_bits(2));
                rd_req[p]  = all_rd || (rand_bits(fill ? 7 : 3) == 0);
            end
            advance();
        end
    endtask

    task automatic drain_all();
        int  n;
        n = 0;
        wea = 1'b0;
        while (n_out > 0 || wr_beats > 0 || enq_pend || (|reading)) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                rd_req[p] = 1'b0;
                for (int q = `NUM_PRIO - 1; q >= 0; q--) begin
                    if (m_cnt[p][q] > 0) begin
                        rd_req[p]  = 1'b1;
                        rd_prio[p] = prio_t'(q);
                    end
                end
            end
            advance();
            n++;
            if (n > 4000) timeout_abort("draining the queues");
        end
        rd_req = '0;
    endtask

    initial begin
        int n;
        int first;
        wea       = 1'b0;
        w_size    = '0;
        prio      = '0;
        dest_port = '0;
        rd_req    = '0;
        rd_prio   = '0;
        rst       = 1'b1;
        lfsr      = 16'h0001;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_eq(int'(writing), 0, "writing after reset");
        check_eq(int'(wr_drop), 0, "wr_drop after reset");
        check_eq(int'(reading), 0, "reading after reset");

        run_traffic(800, 1'b1);
        run_traffic(3000, 1'b0);
        drain_all();

        n = 0;
        while (quiet < QUIET_MIN) begin
            advance();
            n++;
            if (n > 100) timeout_abort("waiting for slot return");
        end

        // one packet per queue fills the pool exactly
        first = n_accept;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            wea       = 1'b1;
            dest_port = port_t'(i % `NUM_PORTS);
            prio      = prio_t'(i / `NUM_PORTS);
            w_size    = len_t'(1 + rand_bits(5));
            advance();
            wea = 1'b0;
            n = 0;
            while (wr_beats > 0 || enq_pend || writing) begin
                advance();
                n++;
                if (n > 2 * `SLOT_WORDS) timeout_abort("waiting for a write burst");
            end
        end
        check_eq(n_accept - first, `NUM_SLOTS, "writes accepted after drain");
        drain_all();

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/pkt_buf_mgr.sv ====
// packet buffer manager top level
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cfg.svh"

module pkt_buf_mgr (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   wea,
    input  wire buf_pkg::len_t                    w_size,
    input  wire queue_pkg::prio_t                 prio,
    input  wire queue_pkg::port_t                 dest_port,
    output wire buf_pkg::addr_t                   write_address,
    output wire                                   writing,
    output wire                                   wr_drop,
    input  wire [`NUM_PORTS-1:0]                  rd_req,
    input  wire queue_pkg::prio_t [`NUM_PORTS-1:0] rd_prio,
    output wire buf_pkg::addr_t [`NUM_PORTS-1:0]   rd_addr,
    output wire [`NUM_PORTS-1:0]                  reading
);
    import buf_pkg::*;
    import queue_pkg::*;

    // full flags in flat queue number order
    logic [`NUM_PORTS*`NUM_PRIO-1:0] q_full_flat;

    // enqueue bus shared by all ports
    logic [`NUM_PORTS-1:0] enq_valid;
    prio_t                 enq_prio;
    slot_t                 enq_slot;
    len_t                  enq_len;

    logic [`NUM_PORTS-1:0]  free_valid;
    slot_t [`NUM_PORTS-1:0] free_slot;
    logic                   ret_valid;
    slot_t                  ret_slot;

    slot_allocator u_alloc (
        .clk           (clk),
        .rst           (rst),
        .wea           (wea),
        .w_size        (w_size),
        .prio          (prio),
        .dest_port     (dest_port),
        .q_full        (q_full_flat),
        .ret_valid     (ret_valid),
        .ret_slot      (ret_slot),
        .write_address (write_address),
        .writing       (writing),
        .wr_drop       (wr_drop),
        .enq_valid     (enq_valid),
        .enq_prio      (enq_prio),
        .enq_slot      (enq_slot),
        .enq_len       (enq_len)
    );

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
        port_queue u_queue (
            .clk        (clk),
            .rst        (rst),
            .enq_valid  (enq_valid[p]),
            .enq_prio   (enq_prio),
            .enq_slot   (enq_slot),
            .enq_len    (enq_len),
            .rd_req     (rd_req[p]),
            .rd_prio    (rd_prio[p]),
            .q_full     (q_full_flat[p*`NUM_PRIO +: `NUM_PRIO]), // port p, all prios
            .rd_addr    (rd_addr[p]),
            .reading    (reading[p]),
            .free_valid (free_valid[p]),
            .free_slot  (free_slot[p])
        );
    end

    slot_release u_release (
        .clk        (clk),
        .rst        (rst),
        .free_valid (free_valid),
        .free_slot  (free_slot),
        .ret_valid  (ret_valid),
        .ret_slot   (ret_slot)
    );

endmodule

`default_nettype wire

// ==== src/slot_release.sv ====
// freed slot collection and return
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cfg.svh"

module slot_release (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire [`NUM_PORTS-1:0]                free_valid,
    input  wire buf_pkg::slot_t [`NUM_PORTS-1:0] free_slot,
    output logic                                ret_valid,
    output buf_pkg::slot_t                      ret_slot
);
    import buf_pkg::*;

    slot_vec_t pending;    // freed, not yet returned
    slot_vec_t incoming;
    slot_vec_t drain_mask;
    slot_t     low_slot;

    // frees from several ports in one cycle all land here
    always_comb begin
        incoming = '0;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (free_valid[p]) incoming[free_slot[p]] = 1'b1;
        end
    end

    assign low_slot = lowest_slot(pending);

    always_comb begin
        drain_mask = '0;
        if (|pending) drain_mask[low_slot] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= '0;
            ret_valid <= 1'b0;
        end else begin
            pending   <= (pending & ~drain_mask) | incoming;
            ret_valid <= |pending;                      // one slot per cycle
        end
    end

    always_ff @(posedge clk) begin
        ret_slot <= low_slot;
    end

endmodule

`default_nettype wire

// ==== src/port_queue.sv ====
// per port priority fifos and read burst
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cfg.svh"

module port_queue (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   enq_valid,
    input  wire queue_pkg::prio_t enq_prio,
    input  wire buf_pkg::slot_t   enq_slot,
    input  wire buf_pkg::len_t    enq_len,
    input  wire                   rd_req,
    input  wire queue_pkg::prio_t rd_prio,
    output queue_pkg::prio_vec_t  q_full,
    output buf_pkg::addr_t        rd_addr,
    output logic                  reading,
    output logic                  free_valid,
    output buf_pkg::slot_t        free_slot
);
    import buf_pkg::*;
    import queue_pkg::*;

    localparam int PTR_W = $clog2(`Q_DEPTH);

    slot_t            slot_mem [`NUM_PRIO][`Q_DEPTH];  // descriptor slot field
    len_t             len_mem  [`NUM_PRIO][`Q_DEPTH];  // descriptor length field
    logic [PTR_W-1:0] wr_ptr   [`NUM_PRIO];
    logic [PTR_W-1:0] rd_ptr   [`NUM_PRIO];
    logic [PTR_W:0]   count    [`NUM_PRIO];           // 0 .. Q_DEPTH
    slot_t            head_slot;
    len_t             head_len;
    prio_vec_t        push;
    prio_vec_t        pop;
    logic             rd_ok;
    len_t             beats_left;

    // head of the requested priority
    assign head_slot = slot_mem[rd_prio][rd_ptr[rd_prio]];
    assign head_len  = len_mem[rd_prio][rd_ptr[rd_prio]];

    // empty queue or busy port ignores the request
    assign rd_ok = rd_req && !reading && (count[rd_prio] != '0);

    always_comb begin
        for (int p = 0; p < `NUM_PRIO; p++) begin
            push[p]   = enq_valid && (enq_prio == prio_t'(p));
            pop[p]    = rd_ok && (rd_prio == prio_t'(p));
            q_full[p] = (count[p] == (PTR_W+1)'(`Q_DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < `NUM_PRIO; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
            reading    <= 1'b0;
            free_valid <= 1'b0;
            rd_addr    <= '0;
            beats_left <= '0;
        end else begin
            for (int p = 0; p < `NUM_PRIO; p++) begin
                if (push[p]) wr_ptr[p] <= wr_ptr[p] + PTR_W'(1);
                if (pop[p]) rd_ptr[p] <= rd_ptr[p] + PTR_W'(1);
                case ({push[p], pop[p]})
                    2'b10:   count[p] <= count[p] + (PTR_W+1)'(1);
                    2'b01:   count[p] <= count[p] - (PTR_W+1)'(1);
                    default: count[p] <= count[p];      // both or neither
                endcase
            end

            free_valid <= rd_ok;                        // slot leaves with the pop
            if (rd_ok) begin
                reading    <= 1'b1;
                rd_addr    <= slot_base(head_slot);
                beats_left <= head_len - len_t'(1);
            end else if (reading) begin
                if (beats_left == '0) begin
                    reading <= 1'b0;
                end else begin
                    rd_addr    <= rd_addr + addr_t'(1);
                    beats_left <= beats_left - len_t'(1);
                end
            end
        end
    end

    // descriptor storage
    always_ff @(posedge clk) begin
        if (enq_valid) begin
            slot_mem[enq_prio][wr_ptr[enq_prio]] <= enq_slot;
            len_mem[enq_prio][wr_ptr[enq_prio]]  <= enq_len;
        end
        if (rd_ok) free_slot <= head_slot;
    end

endmodule

`default_nettype wire

// ==== src/slot_allocator.sv ====
// free slot pool and write address burst
`timescale 1ns/1ps
`default_nettype none
`include "pkt_cfg.svh"

module slot_allocator (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              wea,
    input  wire buf_pkg::len_t               w_size,
    input  wire queue_pkg::prio_t            prio,
    input  wire queue_pkg::port_t            dest_port,
    input  wire [`NUM_PORTS*`NUM_PRIO-1:0]   q_full,
    input  wire                              ret_valid,
    input  wire buf_pkg::slot_t              ret_slot,
    output buf_pkg::addr_t                   write_address,
    output logic                             writing,
    output logic                             wr_drop,
    output logic [`NUM_PORTS-1:0]            enq_valid,
    output queue_pkg::prio_t                 enq_prio,
    output buf_pkg::slot_t                   enq_slot,
    output buf_pkg::len_t                    enq_len
);
    import buf_pkg::*;
    import queue_pkg::*;

    slot_vec_t free_map;   // set bit = slot free
    slot_vec_t alloc_mask;
    slot_vec_t ret_mask;
    slot_t     pick_slot;  // lowest free slot
    logic      pick_found;
    qsel_u     qsel;
    logic      try_wr;
    logic      accept;
    len_t      words_left; // beats after the current one

    assign pick_slot  = lowest_slot(free_map);
    assign pick_found = |free_map;

    always_comb begin
        qsel.fields.port = dest_port;
        qsel.fields.prio = prio;
    end

    assign try_wr = wea && !writing;                              // no new packet mid burst
    assign accept = try_wr && pick_found && !q_full[qsel.flat];

    always_comb begin
        alloc_mask = '0;
        ret_mask   = '0;
        if (accept) alloc_mask[pick_slot] = 1'b1;
        if (ret_valid) ret_mask[ret_slot] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free_map      <= '1;
            writing       <= 1'b0;
            wr_drop       <= 1'b0;
            enq_valid     <= '0;
            write_address <= '0;
            words_left    <= '0;
        end else begin
            free_map  <= (free_map & ~alloc_mask) | ret_mask;
            wr_drop   <= try_wr && !accept;                       // no slot or queue full
            enq_valid <= '0;
            if (accept) begin
                writing                     <= 1'b1;
                write_address               <= slot_base(pick_slot);
                words_left                  <= w_size - len_t'(1);
                enq_valid[qsel.fields.port] <= 1'b1;              // same edge as writing
            end else if (writing) begin
                if (words_left == '0) begin
                    writing <= 1'b0;
                end else begin
                    write_address <= write_address + addr_t'(1);
                    words_left    <= words_left - len_t'(1);
                end
            end
        end
    end

    // descriptor for the target queue
    always_ff @(posedge clk) begin
        if (accept) begin
            enq_prio <= qsel.fields.prio;
            enq_slot <= pick_slot;
            enq_len  <= w_size;
        end
    end

endmodule

`default_nettype wire

// ==== src/queue_pkg.sv ====
// port, priority and queue select types
`default_nettype none
`include "pkt_cfg.svh"

package queue_pkg;
    typedef logic [$clog2(`NUM_PORTS)-1:0] port_t;     // output port number
    typedef logic [$clog2(`NUM_PRIO)-1:0]  prio_t;     // priority level
    typedef logic [`NUM_PRIO-1:0]          prio_vec_t; // one bit per priority

    // one queue select word, read either as a flat queue number
    // (port * NUM_PRIO + prio) or as its port and priority fields
    typedef union packed {
        logic [$clog2(`NUM_PORTS*`NUM_PRIO)-1:0] flat;
        struct packed {
            port_t port; // upper bits
            prio_t prio; // lower bits
        } fields;
    } qsel_u;
endpackage

`default_nettype wire

// ==== src/buf_pkg.sv ====
// buffer slot and address types
`default_nettype none
`include "pkt_cfg.svh"

package buf_pkg;
    typedef logic [$clog2(`NUM_SLOTS)-1:0]             slot_t;     // slot index
    typedef logic [$clog2(`NUM_SLOTS*`SLOT_WORDS)-1:0] addr_t;     // word address
    typedef logic [$clog2(`SLOT_WORDS):0]              len_t;      // 1 .. SLOT_WORDS
    typedef logic [`NUM_SLOTS-1:0]                     slot_vec_t; // one bit per slot

    // first word of a slot
    function automatic addr_t slot_base(slot_t s);
        return addr_t'(s) * addr_t'(`SLOT_WORDS);
    endfunction

    // lowest set bit or 0 for an empty vector
    function automatic slot_t lowest_slot(slot_vec_t v);
        slot_t s;
        s = '0;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
            if (v[i]) s = slot_t'(i);
        end
        return s;
    endfunction
endpackage

`default_nettype wire

// ==== src/pkt_cfg.svh ====
// packet buffer manager sizes
`ifndef PKT_CFG_SVH
`define PKT_CFG_SVH

// output ports of the switch
`define NUM_PORTS 4

// priorities per port
`define NUM_PRIO 4

// descriptors per priority fifo
`define Q_DEPTH 4

// fixed size slots in the pool
`define NUM_SLOTS 16

// words per slot and max packet length
`define SLOT_WORDS 32

`endif
